//--- Makefile
# Verilator build and run of the icache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

test: build
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "no pass result in log"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

//--- design/icache_hit.sv
// icache hit stage: tag compare, word select, miss/non-cacheable/invalidate FSM, memory command

`timescale 1ns/1ps

module icache_hit (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic                                                   req_q_i,
  input  logic                                                   cacheable_q_i,
  input  icache_pkg::cache_adr_u                                 adr_q_i,
  input  logic                                                   flush_i,
  input  logic                                                   invalidate_i,
  input  logic [icache_pkg::WAYS-1:0]                            victim_i,
  input  logic [icache_pkg::WAYS-1:0]                            way_valid_i,
  input  logic [icache_pkg::WAYS-1:0][icache_pkg::TAG_BITS-1:0]  way_tag_i,
  input  logic [icache_pkg::WAYS-1:0][icache_pkg::LINE_BITS-1:0] way_line_i,
  output logic                                                   stall_o,
  output logic [icache_pkg::WAYS-1:0]                            fill_en_o,
  output logic [icache_pkg::TAG_BITS-1:0]                        fill_tag_o,
  output logic [icache_pkg::LINE_BITS-1:0]                       fill_line_o,
  output logic                                                   inval_all_o,
  output logic                                                   mem_req_o,
  output logic                                                   mem_nc_o,
  output logic [icache_pkg::ADR_BITS-1:0]                        mem_adr_o,
  input  logic                                                   mem_ack_i,
  input  logic                                                   mem_err_i,
  input  logic [icache_pkg::LINE_BITS-1:0]                       mem_line_i,
  output logic [icache_pkg::WORD_BITS-1:0]                       parcel_o,
  output logic                                                   parcel_valid_o,
  output logic                                                   parcel_error_o
);

  import icache_pkg::*;

  fsm_state_e           state_q;
  fsm_state_e           state_d;
  logic                 inv_q;
  logic                 inv_pend;
  logic                 err_q;
  logic                 live_req;
  logic                 mem_done;
  logic [WAYS-1:0]      way_hit;
  logic                 hit;
  logic [LINE_BITS-1:0] hit_line;
  logic [WORD_BITS-1:0] hit_word;
  cache_adr_u           line_adr;
  cache_adr_u           word_adr;

  ////////////////////////////////////////
  // tag compare
  ////////////////////////////////////////

  assign way_hit = way_valid_i & {way_tag_i[1] == adr_q_i.cache.tag,
                                  way_tag_i[0] == adr_q_i.cache.tag};
  assign hit     = |way_hit;

  // at most one way hits, so OR the masked lines
  always_comb
  begin
    hit_line = '0;
    for (int w = 0; w < WAYS; w++)
      if (way_hit[w])
        hit_line = hit_line | way_line_i[w];
  end

  assign hit_word = hit_line[adr_q_i.cache.wsel * WORD_BITS +: WORD_BITS];

  // held request that was not flushed this cycle
  assign live_req = req_q_i & ~flush_i;
  // memory answered the outstanding command
  assign mem_done = mem_req_o & mem_ack_i;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  // invalidate pulse waits here until INVALIDATE runs
  assign inv_pend = invalidate_i | inv_q;

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      ARMED:
      begin
        if (inv_pend)
          state_d = INVALIDATE;
        else if (err_q)
          // failed fill, error parcel goes out now
          state_d = ARMED;
        else if (live_req && !cacheable_q_i)
          state_d = NONCACHEABLE;
        else if (live_req && !hit)
          state_d = READ;
      end
      INVALIDATE:   state_d = RECOVER0;
      NONCACHEABLE: if (mem_done) state_d = ARMED;
      READ:         if (mem_done) state_d = RECOVER0;
      // two cycles so the ways read the held set again
      RECOVER0:     state_d = RECOVER1;
      RECOVER1:     state_d = ARMED;
      default:      state_d = ARMED;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q   <= ARMED;
      inv_q     <= 1'b0;
      err_q     <= 1'b0;
      mem_req_o <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      inv_q   <= invalidate_i | (inv_q & (state_q != INVALIDATE));
      // remember a failed line read for the replay in ARMED
      if (state_q == READ && mem_done)
        err_q <= mem_err_i;
      else if (state_q == ARMED && !inv_pend)
        err_q <= 1'b0;
      // raised on leaving ARMED, dropped the cycle after the ack
      if (state_q == ARMED && (state_d == READ || state_d == NONCACHEABLE))
        mem_req_o <= 1'b1;
      else if (mem_ack_i)
        mem_req_o <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // fill, invalidate and memory command
  ////////////////////////////////////////

  // line goes to the victim way at the ack edge, not on error
  assign fill_en_o   = (state_q == READ && mem_done && !mem_err_i) ? victim_i : '0;
  assign fill_tag_o  = adr_q_i.cache.tag;
  assign fill_line_o = mem_line_i;
  assign inval_all_o = (state_q == INVALIDATE);
  assign mem_nc_o    = (state_q == NONCACHEABLE);

  // line-aligned through the cache view, word-aligned through the bus view
  always_comb
  begin
    line_adr            = adr_q_i;
    line_adr.cache.wsel = '0;
    line_adr.cache.boff = '0;
    word_adr            = adr_q_i;
    word_adr.bus.boff   = '0;
  end

  assign mem_adr_o = mem_nc_o ? word_adr : line_adr;

  ////////////////////////////////////////
  // stall and parcel
  ////////////////////////////////////////

  always_comb
  begin
    unique case (state_q)
      ARMED:        stall_o = inv_pend | (live_req & ~err_q & (~cacheable_q_i | ~hit));
      NONCACHEABLE: stall_o = ~mem_done;
      default:      stall_o = 1'b1;
    endcase
  end

  // an error response still delivers a parcel, flagged
  always_comb
  begin
    unique case (state_q)
      ARMED:
      begin
        parcel_valid_o = ~inv_pend & live_req & (err_q | (cacheable_q_i & hit));
        parcel_error_o = ~inv_pend & live_req & err_q;
      end
      NONCACHEABLE:
      begin
        parcel_valid_o = live_req & mem_done;
        parcel_error_o = live_req & mem_done & mem_err_i;
      end
      default:
      begin
        parcel_valid_o = 1'b0;
        parcel_error_o = 1'b0;
      end
    endcase
  end

  // non-cacheable word comes straight off the bus
  assign parcel_o = mem_nc_o ? mem_line_i[WORD_BITS-1:0] : hit_word;

endmodule

//--- design/icache_lookup.sv
// icache lookup stage: request register, way read index and per-set victim bits

`timescale 1ns/1ps

module icache_lookup (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  logic                          cacheable_i,
  input  logic                          flush_i,
  input  icache_pkg::cache_adr_u        adr_i,
  input  logic                          stall_i,
  input  logic                          fill_en_i,
  input  logic                          inval_all_i,
  output logic                          req_q_o,
  output logic                          cacheable_q_o,
  output icache_pkg::cache_adr_u        adr_q_o,
  output logic [icache_pkg::IDX_BITS-1:0] rd_idx_o,
  output logic [icache_pkg::WAYS-1:0]   victim_o
);

  import icache_pkg::*;

  // one toggle bit per set, selects the next way to replace
  logic [SETS-1:0] victim_q;

  // request valid
  // flush only kills what is already held
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      req_q_o <= 1'b0;
    else if (!stall_i)
      req_q_o <= req_i;
    else if (flush_i)
      req_q_o <= 1'b0;
  end

  // request payload, loaded on accept
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      cacheable_q_o <= cacheable_i;
      adr_q_o       <= adr_i;
    end
  end

  // new index when accepting, else keep reading the held set
  // (this is also what re-reads the ways during recover)
  assign rd_idx_o = stall_i ? adr_q_o.cache.idx : adr_i.cache.idx;

  // victim bits follow fills of the held set
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      victim_q <= '0;
    else if (inval_all_i)
      victim_q <= '0;
    else if (fill_en_i)
      victim_q[adr_q_o.cache.idx] <= ~victim_q[adr_q_o.cache.idx];
  end

  // bit clear picks way 0, bit set picks way 1
  assign victim_o = {victim_q[adr_q_o.cache.idx], ~victim_q[adr_q_o.cache.idx]};

endmodule

//--- design/icache_pkg.sv
// icache geometry constants, fetch address union and hit-stage state encoding

package icache_pkg;

  ////////////////////////////////////////
  // geometry
  ////////////////////////////////////////

  // physical fetch address
  localparam int ADR_BITS       = 16;
  // one instruction word
  localparam int WORD_BITS      = 32;

  // 2-way set associative, 8 sets
  localparam int WAYS           = 2;
  localparam int SETS           = 8;
  localparam int IDX_BITS       = $clog2(SETS);

  // 4 words per line
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_BITS      = WORDS_PER_LINE * WORD_BITS;

  // whatever is left above index, word select and byte offset
  localparam int TAG_BITS       = ADR_BITS - IDX_BITS - $clog2(WORDS_PER_LINE) - 2;

  ////////////////////////////////////////
  // address views
  ////////////////////////////////////////

  // one address word, decoded two ways
  typedef union packed {
    // cache view, for indexing and tag compare
    struct packed {
      logic [TAG_BITS-1:0]               tag;
      logic [IDX_BITS-1:0]               idx;
      logic [$clog2(WORDS_PER_LINE)-1:0] wsel;
      logic [1:0]                        boff;
    } cache;
    // bus view, word address plus byte lanes
    struct packed {
      logic [ADR_BITS-3:0]               wadr;
      logic [1:0]                        boff;
    } bus;
  } cache_adr_u;

  ////////////////////////////////////////
  // hit-stage states
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    ARMED,
    INVALIDATE,
    NONCACHEABLE,
    READ,
    RECOVER0,
    RECOVER1
  } fsm_state_e;

endpackage

//--- design/icache_top.sv
// icache top: lookup stage, generated ways and hit stage

`timescale 1ns/1ps

module icache_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // core side
  input  logic                             req_i,
  input  logic [icache_pkg::ADR_BITS-1:0]  adr_i,
  input  logic                             cacheable_i,
  input  logic                             flush_i,
  input  logic                             invalidate_i,
  output logic                             stall_o,
  output logic [icache_pkg::WORD_BITS-1:0] parcel_o,
  output logic                             parcel_valid_o,
  output logic                             parcel_error_o,
  // memory side
  output logic                             mem_req_o,
  output logic [icache_pkg::ADR_BITS-1:0]  mem_adr_o,
  output logic                             mem_nc_o,
  input  logic                             mem_ack_i,
  input  logic [icache_pkg::LINE_BITS-1:0] mem_line_i,
  input  logic                             mem_err_i
);

  import icache_pkg::*;

  // lookup stage outputs
  logic                            req_q;
  logic                            cacheable_q;
  cache_adr_u                      adr_q;
  logic [IDX_BITS-1:0]             rd_idx;
  logic [WAYS-1:0]                 victim;

  // hit stage to lookup and ways
  logic [WAYS-1:0]                 fill_en;
  logic [TAG_BITS-1:0]             fill_tag;
  logic [LINE_BITS-1:0]            fill_line;
  logic                            inval_all;

  // per-way read data
  logic [WAYS-1:0]                 way_valid;
  logic [WAYS-1:0][TAG_BITS-1:0]   way_tag;
  logic [WAYS-1:0][LINE_BITS-1:0]  way_line;

  ////////////////////////////////////////
  // lookup stage
  ////////////////////////////////////////

  icache_lookup u_lookup (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .cacheable_i   (cacheable_i),
    .flush_i       (flush_i),
    .adr_i         (adr_i),
    .stall_i       (stall_o),
    .fill_en_i     (|fill_en),
    .inval_all_i   (inval_all),
    .req_q_o       (req_q),
    .cacheable_q_o (cacheable_q),
    .adr_q_o       (adr_q),
    .rd_idx_o      (rd_idx),
    .victim_o      (victim)
  );

  ////////////////////////////////////////
  // ways
  ////////////////////////////////////////

  for (genvar g = 0; g < WAYS; g++)
  begin : g_way
    // each way writes on its own bit of the one-hot fill select
    icache_way u_way (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .rd_idx_i    (rd_idx),
      .fill_en_i   (fill_en[g]),
      .fill_idx_i  (adr_q.cache.idx),
      .fill_tag_i  (fill_tag),
      .fill_line_i (fill_line),
      .inval_all_i (inval_all),
      .valid_o     (way_valid[g]),
      .tag_o       (way_tag[g]),
      .line_o      (way_line[g])
    );
  end

  ////////////////////////////////////////
  // hit stage
  ////////////////////////////////////////

  icache_hit u_hit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_q_i        (req_q),
    .cacheable_q_i  (cacheable_q),
    .adr_q_i        (adr_q),
    .flush_i        (flush_i),
    .invalidate_i   (invalidate_i),
    .victim_i       (victim),
    .way_valid_i    (way_valid),
    .way_tag_i      (way_tag),
    .way_line_i     (way_line),
    .stall_o        (stall_o),
    .fill_en_o      (fill_en),
    .fill_tag_o     (fill_tag),
    .fill_line_o    (fill_line),
    .inval_all_o    (inval_all),
    .mem_req_o      (mem_req_o),
    .mem_nc_o       (mem_nc_o),
    .mem_adr_o      (mem_adr_o),
    .mem_ack_i      (mem_ack_i),
    .mem_err_i      (mem_err_i),
    .mem_line_i     (mem_line_i),
    .parcel_o       (parcel_o),
    .parcel_valid_o (parcel_valid_o),
    .parcel_error_o (parcel_error_o)
  );

endmodule

//--- design/icache_way.sv
// icache way: valid flops, tag array and line data array with registered read

`timescale 1ns/1ps

module icache_way (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic [icache_pkg::IDX_BITS-1:0]  rd_idx_i,
  input  logic                             fill_en_i,
  input  logic [icache_pkg::IDX_BITS-1:0]  fill_idx_i,
  input  logic [icache_pkg::TAG_BITS-1:0]  fill_tag_i,
  input  logic [icache_pkg::LINE_BITS-1:0] fill_line_i,
  input  logic                             inval_all_i,
  output logic                             valid_o,
  output logic [icache_pkg::TAG_BITS-1:0]  tag_o,
  output logic [icache_pkg::LINE_BITS-1:0] line_o
);

  import icache_pkg::*;

  logic [SETS-1:0]      valid_q;
  logic [TAG_BITS-1:0]  tag_mem  [SETS];
  logic [LINE_BITS-1:0] line_mem [SETS];

  ////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////

  // invalidate clears every set at once
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      valid_q <= '0;
    else if (inval_all_i)
      valid_q <= '0;
    else if (fill_en_i)
      valid_q[fill_idx_i] <= 1'b1;
  end

  // registered read, returns the old value on a same-edge fill
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      valid_o <= 1'b0;
    else
      valid_o <= valid_q[rd_idx_i];
  end

  ////////////////////////////////////////
  // tag and data arrays
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (fill_en_i)
    begin
      tag_mem[fill_idx_i]  <= fill_tag_i;
      line_mem[fill_idx_i] <= fill_line_i;
    end
    tag_o  <= tag_mem[rd_idx_i];
    line_o <= line_mem[rd_idx_i];
  end

endmodule

//--- flist.f
design/icache_pkg.sv
design/icache_lookup.sv
design/icache_way.sv
design/icache_hit.sv
design/icache_top.sv
sim/icache_asserts.sv
sim/tb_icache.sv

//--- sim/icache_asserts.sv
// icache hit-stage protocol assertions, bound into every icache_hit instance

`timescale 1ns/1ps

module icache_asserts (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  icache_pkg::fsm_state_e            state_q,
  input  logic                              mem_req_o,
  input  logic                              mem_ack_i,
  input  logic [icache_pkg::ADR_BITS-1:0]   mem_adr_o,
  input  logic                              stall_o,
  input  logic [icache_pkg::WAYS-1:0]       fill_en_o
);

  import icache_pkg::*;

  // command held with a steady address until memory answers
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_adr_o))
    else $error("memory command dropped or address moved before ack");

  // a cycle without stall always leads into ARMED
  // every other state is entered and kept with the core held
  a_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !stall_o |=> state_q == ARMED)
    else $error("core released while the FSM moves out of ARMED");

  // fill goes to one way at most
  a_fill_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(fill_en_o))
    else $error("fill enable hits more than one way");

endmodule

bind icache_hit icache_asserts u_asserts (.*);

//--- sim/tb_icache.sv
// icache testbench: clock, reset, random fetches, memory responder, reference model, checks

`timescale 1ns/1ps

module tb_icache;

  import icache_pkg::*;

  localparam int N_REQ = 400;
  localparam int LIMIT = N_REQ * 12;

  logic clk_i, rst_ni, req_i, cacheable_i, flush_i, invalidate_i;
  logic [ADR_BITS-1:0] adr_i, mem_adr_o;
  logic stall_o, parcel_valid_o, parcel_error_o, mem_req_o, mem_nc_o;
  logic mem_ack_i, mem_err_i;
  logic [WORD_BITS-1:0] parcel_o;
  logic [LINE_BITS-1:0] mem_line_i;

  // reference model of valid, tag and victim state
  logic                m_valid [WAYS][SETS];
  logic [TAG_BITS-1:0] m_tag   [WAYS][SETS];
  logic                m_vict  [SETS];

  // expected parcels and memory commands, in order
  logic [ADR_BITS-1:0] exp_adr_q[$];
  logic                exp_err_q[$];
  logic [ADR_BITS-1:0] mem_adr_q[$];
  logic                mem_nc_q[$];
  logic                mem_err_q[$];

  int   sent, cycles, mem_wait;
  logic accepted, flush_pending, inval_pending, mem_busy, mem_err_cur;
  logic cur_flush, cur_err;

  icache_top u_dut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // run limit from the request count
  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles == LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // memory contents, a fixed mix of the word address
  function automatic logic [31:0] word_of(input logic [13:0] wadr);
    return (32'(wadr) * 32'h9E37_79B9) ^ {wadr, 18'h0} ^ 32'h5A5A_1234;
  endfunction

  function automatic logic [LINE_BITS-1:0] line_of(input logic [ADR_BITS-1:0] adr);
    logic [LINE_BITS-1:0] l;
    for (int w = 0; w < WORDS_PER_LINE; w++)
      l[w*WORD_BITS +: WORD_BITS] = word_of({adr[15:4], 2'(w)});
    return l;
  endfunction

  function automatic logic is_idle();
    return !req_i && !accepted && !flush_pending && !mem_busy &&
           exp_adr_q.size() == 0 && mem_adr_q.size() == 0;
  endfunction

  // model update for a request accepted at the coming edge
  task automatic accept_request();
    logic                hit;
    logic [IDX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] tag;
    int                  w;
    idx = adr_i[6:4];
    tag = adr_i[15:7];
    hit = 1'b0;
    if (cur_flush)
      flush_pending = 1'b1;
    else if (!cacheable_i)
    begin
      mem_adr_q.push_back(adr_i & 16'hFFFC);
      mem_nc_q.push_back(1'b1);
      mem_err_q.push_back(cur_err);
      exp_adr_q.push_back(adr_i);
      exp_err_q.push_back(cur_err);
    end
    else
    begin
      for (int i = 0; i < WAYS; i++)
        if (m_valid[i][idx] && m_tag[i][idx] == tag)
          hit = 1'b1;
      if (!hit)
      begin
        mem_adr_q.push_back(adr_i & 16'hFFF0);
        mem_nc_q.push_back(1'b0);
        mem_err_q.push_back(cur_err);
        // failed fill leaves the set as it was
        if (!cur_err)
        begin
          w = int'(m_vict[idx]);
          m_valid[w][idx] = 1'b1;
          m_tag[w][idx]   = tag;
          m_vict[idx]     = ~m_vict[idx];
        end
      end
      exp_adr_q.push_back(adr_i);
      exp_err_q.push_back(hit ? 1'b0 : cur_err);
    end
  endtask

  task automatic run_cycle();
    logic [ADR_BITS-1:0] a;
    logic                e;
    @(negedge clk_i);
    ////////////////////////////////////////
    // memory responder
    mem_ack_i  = 1'b0;
    mem_err_i  = 1'b0;
    mem_line_i = '0;
    if (mem_req_o && !mem_busy)
    begin
      check_eq("memory command without a pending miss", 32'(mem_adr_q.size() != 0), 1);
      check_eq("memory address", 32'(mem_adr_o), 32'(mem_adr_q.pop_front()));
      check_eq("memory nc flag", 32'(mem_nc_o), 32'(mem_nc_q.pop_front()));
      mem_err_cur = mem_err_q.pop_front();
      mem_busy    = 1'b1;
      mem_wait    = $urandom_range(0, 3);
    end
    if (mem_busy)
    begin
      if (mem_wait == 0)
      begin
        mem_ack_i  = 1'b1;
        mem_err_i  = mem_err_cur;
        mem_line_i = mem_nc_o ? {96'h0, word_of(mem_adr_o[15:2])} : line_of(mem_adr_o);
        mem_busy   = 1'b0;
      end
      else
        mem_wait--;
    end
    ////////////////////////////////////////
    // core side
    flush_i      = 1'b0;
    invalidate_i = 1'b0;
    if (accepted)
    begin
      req_i    = 1'b0;
      accepted = 1'b0;
    end
    if (flush_pending)
    begin
      flush_i       = 1'b1;
      flush_pending = 1'b0;
    end
    else if (inval_pending && is_idle())
    begin
      invalidate_i  = 1'b1;
      inval_pending = 1'b0;
      for (int s = 0; s < SETS; s++)
      begin
        m_valid[0][s] = 1'b0;
        m_valid[1][s] = 1'b0;
        m_vict[s]     = 1'b0;
      end
    end
    else if (!req_i && !inval_pending && sent < N_REQ && $urandom_range(0, 3) != 0)
    begin
      // three tags per set against two ways, so lines get evicted
      adr_i       = {9'($urandom_range(0, 2)), 3'($urandom_range(0, 7)),
                     2'($urandom_range(0, 3)), 2'($urandom_range(0, 3))};
      cacheable_i = ($urandom_range(0, 4) != 0);
      cur_flush   = ($urandom_range(0, 9) == 0);
      cur_err     = ($urandom_range(0, 11) == 0);
      req_i       = 1'b1;
      sent++;
      if (sent % 50 == 25)
        inval_pending = 1'b1;
    end
    #1;
    // outputs are settled for the coming edge
    if (req_i && !accepted && !stall_o)
    begin
      accepted = 1'b1;
      accept_request();
    end
    if (parcel_valid_o)
    begin
      check_eq("parcel with nothing outstanding", 32'(exp_adr_q.size() != 0), 1);
      a = exp_adr_q.pop_front();
      e = exp_err_q.pop_front();
      check_eq("parcel error flag", 32'(parcel_error_o), 32'(e));
      if (!e)
        check_eq("parcel data", parcel_o, word_of(a[15:2]));
    end
  endtask

  initial
  begin
    void'($urandom(51));
    rst_ni = 1'b0;
    req_i = 1'b0;
    adr_i = '0;
    cacheable_i = 1'b0;
    flush_i = 1'b0;
    invalidate_i = 1'b0;
    mem_ack_i = 1'b0;
    mem_err_i = 1'b0;
    mem_line_i = '0;
    cycles = 0;
    sent = 0;
    mem_wait = 0;
    accepted = 1'b0;
    flush_pending = 1'b0;
    inval_pending = 1'b0;
    mem_busy = 1'b0;
    mem_err_cur = 1'b0;
    for (int s = 0; s < SETS; s++)
    begin
      m_valid[0][s] = 1'b0;
      m_valid[1][s] = 1'b0;
      m_vict[s]     = 1'b0;
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    while (sent < N_REQ || inval_pending || !is_idle())
      run_cycle();
    // nothing late may show up
    repeat (8) run_cycle();
    $display("RESULT: PASS");
    $finish;
  end

endmodule
